/* hw/ex_pkg.sv */
package ex_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data and address word
    localparam int WORD_W = 32;

    //////////////////////////////
    // Opcodes and kinds
    //////////////////////////////

    // Four-bit ALU opcode encoding
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_NOR = 4'b1100,
        ALU_XOR = 4'b1101,
        // Unknown op gives all ones from the ALU
        ALU_BAD = 4'b1111
    } alu_op_e;

    // Operation class from the decoder
    typedef enum logic [1:0] {
        CLS_ADD   = 2'b00,  // Loads, stores, addi
        CLS_SUB   = 2'b01,  // beq and bne compare
        CLS_FUNCT = 2'b10,  // R-type
        CLS_OR    = 2'b11   // ori
    } alu_class_e;

    // Branch kind
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_EQ   = 2'b01,
        BR_NE   = 2'b10,
        BR_JUMP = 2'b11
    } branch_e;

    //////////////////////////////
    // Stage boundary structs
    //////////////////////////////

    // ID/EX boundary
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] pc_plus4;
        logic [WORD_W-1:0] reg_a;
        logic [WORD_W-1:0] reg_b;
        logic [WORD_W-1:0] imm;        // Already sign-extended
        logic              use_imm;
        alu_class_e        alu_class;
        logic [5:0]        funct;
        branch_e           branch;
        logic [25:0]       jump_index;
        logic [4:0]        rd;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } id_ex_t;

    // EX/MEM boundary
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] alu_result;
        logic [WORD_W-1:0] store_data;
        logic [4:0]        rd;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } ex_mem_t;

endpackage

/* hw/alu_control.sv */
`timescale 1ns/100ps

module alu_control
    import ex_pkg::*;
(
    input  alu_class_e i_alu_class,
    input  logic [5:0] i_funct,
    output alu_op_e    o_alu_op
);

    //////////////////////////////
    // MIPS function codes
    //////////////////////////////

    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    // Function field decode, R-type only
    alu_op_e funct_op;

    always_comb
    begin
        case (i_funct)
            FN_AND:           funct_op = ALU_AND;
            FN_OR:            funct_op = ALU_OR;
            FN_ADD, FN_ADDU:  funct_op = ALU_ADD;
            FN_SUB, FN_SUBU:  funct_op = ALU_SUB;
            FN_SLT:           funct_op = ALU_SLT;
            FN_NOR:           funct_op = ALU_NOR;
            FN_XOR:           funct_op = ALU_XOR;
            // Unsupported funct
            default:          funct_op = ALU_BAD;
        endcase
    end

    // Class picks fixed op or funct decode
    always_comb
    begin
        case (i_alu_class)
            CLS_ADD:   o_alu_op = ALU_ADD;
            CLS_SUB:   o_alu_op = ALU_SUB;
            CLS_OR:    o_alu_op = ALU_OR;
            CLS_FUNCT: o_alu_op = funct_op;
            default:   o_alu_op = ALU_BAD;
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu
    import ex_pkg::*;
(
    input  logic [WORD_W-1:0] i_reg,
    input  logic [WORD_W-1:0] i_mux,
    input  alu_op_e           i_op,
    output logic              o_zero,
    output logic [WORD_W-1:0] o_result
);

    //////////////////////////////
    // Operation select
    //////////////////////////////

    logic [WORD_W-1:0] result;

    // Set-less-than is unsigned here
    logic              less_u;

    assign less_u = (i_reg < i_mux);

    always_comb
    begin
        case (i_op)
            ALU_AND:
                result = i_reg & i_mux;
            ALU_OR:
                result = i_reg | i_mux;
            ALU_ADD:
                result = i_reg + i_mux;
            ALU_SUB:
                result = i_reg - i_mux;
            ALU_SLT:
                result = {{(WORD_W-1){1'b0}}, less_u};
            ALU_NOR:
                result = ~(i_reg | i_mux);
            ALU_XOR:
                result = i_reg ^ i_mux;
            // ALU_BAD and anything else
            default:
                result = {WORD_W{1'b1}};
        endcase
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign o_result = result;

    // Zero flag feeds the beq/bne decision
    assign o_zero   = (result == '0);

endmodule

/* hw/branch_addr_unit.sv */
`timescale 1ns/100ps

module branch_addr_unit
    import ex_pkg::*;
(
    input  logic [WORD_W-1:0] i_pc_plus4,
    input  logic [WORD_W-1:0] i_imm,
    input  logic [25:0]       i_jump_index,
    output logic [WORD_W-1:0] o_branch_target,
    output logic [WORD_W-1:0] o_jump_target
);

    //////////////////////////////
    // Branch target
    //////////////////////////////

    // Word offset to byte offset
    logic [WORD_W-1:0] imm_shifted;

    assign imm_shifted = {i_imm[WORD_W-3:0], 2'b00};

    // Own adder, runs beside the ALU
    assign o_branch_target = i_pc_plus4 + imm_shifted;

    //////////////////////////////
    // Jump target
    //////////////////////////////

    // Region bits from pc_plus4
    logic [3:0] pc_region;

    assign pc_region = i_pc_plus4[WORD_W-1:WORD_W-4];

    // Region, index, word aligned
    assign o_jump_target = {pc_region, i_jump_index, 2'b00};

endmodule

/* hw/ex_mem_reg.sv */
`timescale 1ns/100ps

module ex_mem_reg
    import ex_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  id_ex_t            i_id_ex,
    input  logic [WORD_W-1:0] i_alu_result,
    input  logic              i_zero,
    input  logic [WORD_W-1:0] i_branch_target,
    input  logic [WORD_W-1:0] i_jump_target,
    output ex_mem_t           o_ex_mem,
    output logic              o_redirect,
    output logic [WORD_W-1:0] o_redirect_pc
);

    //////////////////////////////
    // Redirect decision
    //////////////////////////////

    logic              taken;
    logic              redirect_d;
    logic [WORD_W-1:0] redirect_pc_d;

    always_comb
    begin
        case (i_id_ex.branch)
            BR_EQ:   taken = i_zero;
            BR_NE:   taken = ~i_zero;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Bubbles never redirect
    assign redirect_d    = i_id_ex.valid & taken;

    // Jump target only for jumps
    assign redirect_pc_d = (i_id_ex.branch == BR_JUMP) ? i_jump_target : i_branch_target;

    //////////////////////////////
    // Next EX/MEM word
    //////////////////////////////

    ex_mem_t ex_mem_d;

    always_comb
    begin
        ex_mem_d.valid      = i_id_ex.valid;
        ex_mem_d.alu_result = i_alu_result;
        ex_mem_d.store_data = i_id_ex.reg_b;
        ex_mem_d.rd         = i_id_ex.rd;
        // Controls masked so a bubble writes nothing
        ex_mem_d.reg_write  = i_id_ex.valid & i_id_ex.reg_write;
        ex_mem_d.mem_read   = i_id_ex.valid & i_id_ex.mem_read;
        ex_mem_d.mem_write  = i_id_ex.valid & i_id_ex.mem_write;
    end

    //////////////////////////////
    // Registers
    //////////////////////////////

    ex_mem_t           ex_mem_q;
    logic              redirect_q;
    logic [WORD_W-1:0] redirect_pc_q;

    // Control bits and redirect
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            ex_mem_q.valid     <= 1'b0;
            ex_mem_q.reg_write <= 1'b0;
            ex_mem_q.mem_read  <= 1'b0;
            ex_mem_q.mem_write <= 1'b0;
            redirect_q         <= 1'b0;
            redirect_pc_q      <= '0;
        end
        else
        begin
            ex_mem_q.valid     <= ex_mem_d.valid;
            ex_mem_q.reg_write <= ex_mem_d.reg_write;
            ex_mem_q.mem_read  <= ex_mem_d.mem_read;
            ex_mem_q.mem_write <= ex_mem_d.mem_write;
            redirect_q         <= redirect_d;
            // Target held until the next redirect
            if (redirect_d)
                redirect_pc_q <= redirect_pc_d;
        end
    end

    // Payload, loaded every cycle
    always_ff @(posedge i_clk)
    begin
        ex_mem_q.alu_result <= ex_mem_d.alu_result;
        ex_mem_q.store_data <= ex_mem_d.store_data;
        ex_mem_q.rd         <= ex_mem_d.rd;
    end

    assign o_ex_mem      = ex_mem_q;
    assign o_redirect    = redirect_q;
    assign o_redirect_pc = redirect_pc_q;

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage
    import ex_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  id_ex_t            i_id_ex,
    output ex_mem_t           o_ex_mem,
    output logic              o_redirect,
    output logic [WORD_W-1:0] o_redirect_pc
);

    //////////////////////////////
    // ALU path
    //////////////////////////////

    alu_op_e           alu_op;
    logic [WORD_W-1:0] alu_operand_b;
    logic [WORD_W-1:0] alu_result;
    logic              alu_zero;

    alu_control alu_control_i (
        .i_alu_class (i_id_ex.alu_class),
        .i_funct     (i_id_ex.funct),
        .o_alu_op    (alu_op)
    );

    // Second operand, immediate or register
    assign alu_operand_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.reg_b;

    alu alu_i (
        .i_reg    (i_id_ex.reg_a),
        .i_mux    (alu_operand_b),
        .i_op     (alu_op),
        .o_zero   (alu_zero),
        .o_result (alu_result)
    );

    //////////////////////////////
    // Address path
    //////////////////////////////

    logic [WORD_W-1:0] branch_target;
    logic [WORD_W-1:0] jump_target;

    branch_addr_unit branch_addr_unit_i (
        .i_pc_plus4      (i_id_ex.pc_plus4),
        .i_imm           (i_id_ex.imm),
        .i_jump_index    (i_id_ex.jump_index),
        .o_branch_target (branch_target),
        .o_jump_target   (jump_target)
    );

    //////////////////////////////
    // EX/MEM boundary
    //////////////////////////////

    ex_mem_reg ex_mem_reg_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_id_ex         (i_id_ex),
        .i_alu_result    (alu_result),
        .i_zero          (alu_zero),
        .i_branch_target (branch_target),
        .i_jump_target   (jump_target),
        .o_ex_mem        (o_ex_mem),
        .o_redirect      (o_redirect),
        .o_redirect_pc   (o_redirect_pc)
    );

endmodule

/* test/ex_stage_props.sv */
`timescale 1ns/100ps

module ex_stage_props
    import ex_pkg::*;
(
    input logic    i_clk,
    input logic    i_rst_n,
    input id_ex_t  i_id_ex,
    input ex_mem_t i_ex_mem,
    input logic    i_redirect
);

    // Registered outputs cleared by reset
    reset_clears: assert property (@(posedge i_clk)
        !i_rst_n |=> (!i_redirect && !i_ex_mem.valid))
        else $error("Redirect or valid set in the cycle after reset");

    // Redirect only from a real instruction
    redirect_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect |-> $past(i_id_ex.valid))
        else $error("Redirect raised for an invalid instruction");

    // Bubbles carry no controls
    controls_need_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_ex_mem.valid |-> !(i_ex_mem.reg_write || i_ex_mem.mem_read || i_ex_mem.mem_write))
        else $error("EX/MEM control bit set without valid");

endmodule

bind ex_stage ex_stage_props ex_stage_props_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_id_ex    (i_id_ex),
    .i_ex_mem   (o_ex_mem),
    .i_redirect (o_redirect)
);

/* test/tb_ex_stage.sv */
`timescale 1ns/100ps

module tb_ex_stage
    import ex_pkg::*;
();

    //////////////////////////////
    // Setup
    //////////////////////////////

    localparam int    CLK_PERIOD_NS = 4;
    localparam int    RESET_CYCLES  = 3;
    localparam int    MARGIN_CYCLES = 20;
    localparam int    NUM_COLUMNS   = 22;
    localparam string STIM_FILE     = "test/ex_stim.txt";

    // One line of the vector file
    typedef struct packed {
        logic [7:0]        id;
        id_ex_t            id_ex;
        logic              exp_valid;
        logic [WORD_W-1:0] exp_alu_result;
        logic              exp_reg_write;
        logic              exp_mem_read;
        logic              exp_mem_write;
        logic              exp_redirect;
        logic [WORD_W-1:0] exp_redirect_pc;
    } vector_t;

    logic              clk;
    logic              rst_n;
    id_ex_t            id_ex;
    ex_mem_t           ex_mem;
    logic              redirect;
    logic [WORD_W-1:0] redirect_pc;

    vector_t vectors[$];
    logic    vectors_loaded;
    int      error_count  = 0;
    int      test_errors  = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;

    ex_stage dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_id_ex       (id_ex),
        .o_ex_mem      (ex_mem),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    // Free-running clock
    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic compare_value(input string name, input logic [WORD_W-1:0] actual,
                                 input logic [WORD_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // One result line per test
    task automatic close_test(input string label);
        if (test_errors == 0)
        begin
            $display("Test %s: ok", label);
            tests_passed++;
        end
        else
        begin
            $display("Test %s: failed with %0d mismatches", label, test_errors);
            tests_failed++;
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [WORD_W-1:0] col [NUM_COLUMNS];
        vector_t           v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file %s", STIM_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18], col[19], col[20], col[21]);
            if (n != NUM_COLUMNS)
            begin
                $display("Vector file line has %0d columns instead of %0d", n, NUM_COLUMNS);
                error_count++;
                continue;
            end
            v                  = '0;
            v.id               = col[0][7:0];
            v.id_ex.valid      = col[1][0];
            v.id_ex.pc_plus4   = col[2];
            v.id_ex.reg_a      = col[3];
            v.id_ex.reg_b      = col[4];
            v.id_ex.imm        = col[5];
            v.id_ex.use_imm    = col[6][0];
            v.id_ex.alu_class  = alu_class_e'(col[7][1:0]);
            v.id_ex.funct      = col[8][5:0];
            v.id_ex.branch     = branch_e'(col[9][1:0]);
            v.id_ex.jump_index = col[10][25:0];
            v.id_ex.rd         = col[11][4:0];
            v.id_ex.reg_write  = col[12][0];
            v.id_ex.mem_read   = col[13][0];
            v.id_ex.mem_write  = col[14][0];
            // Expected side
            v.exp_valid        = col[15][0];
            v.exp_alu_result   = col[16];
            v.exp_reg_write    = col[17][0];
            v.exp_mem_read     = col[18][0];
            v.exp_mem_write    = col[19][0];
            v.exp_redirect     = col[20][0];
            v.exp_redirect_pc  = col[21];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    // Random fill of fields the vector does not care about
    function automatic id_ex_t fill_dont_cares(input id_ex_t vec_in);
        id_ex_t            vec_out;
        logic [WORD_W-1:0] rand_word;
        vec_out = vec_in;
        // Jump index only used by jumps
        if (vec_in.branch != BR_JUMP)
        begin
            rand_word          = $urandom();
            vec_out.jump_index = rand_word[25:0];
        end
        // No register written back
        if (!vec_in.reg_write && !vec_in.mem_read)
        begin
            rand_word  = $urandom();
            vec_out.rd = rand_word[4:0];
        end
        return vec_out;
    endfunction

    task automatic inspect_reset();
        test_errors = 0;
        compare_value("o_ex_mem.valid", ex_mem.valid, 1'b0);
        compare_value("o_ex_mem.reg_write", ex_mem.reg_write, 1'b0);
        compare_value("o_ex_mem.mem_read", ex_mem.mem_read, 1'b0);
        compare_value("o_ex_mem.mem_write", ex_mem.mem_write, 1'b0);
        compare_value("o_redirect", redirect, 1'b0);
        compare_value("o_redirect_pc", redirect_pc, '0);
        close_test("reset");
    endtask

    task automatic score_vector(input vector_t v, input id_ex_t driven);
        test_errors = 0;
        compare_value("o_ex_mem.valid", ex_mem.valid, v.exp_valid);
        compare_value("o_ex_mem.reg_write", ex_mem.reg_write, v.exp_reg_write);
        compare_value("o_ex_mem.mem_read", ex_mem.mem_read, v.exp_mem_read);
        compare_value("o_ex_mem.mem_write", ex_mem.mem_write, v.exp_mem_write);
        compare_value("o_redirect", redirect, v.exp_redirect);
        compare_value("o_redirect_pc", redirect_pc, v.exp_redirect_pc);
        // Payload only defined for a real instruction
        if (v.exp_valid)
        begin
            compare_value("o_ex_mem.alu_result", ex_mem.alu_result, v.exp_alu_result);
            // Store data is reg_b as driven
            compare_value("o_ex_mem.store_data", ex_mem.store_data, driven.reg_b);
            compare_value("o_ex_mem.rd", ex_mem.rd, driven.rd);
        end
        close_test($sformatf("%02h", v.id));
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        int unsigned seed_draw;
        id_ex_t      driven;
        clk            = 1'b0;
        rst_n          = 1'b0;
        id_ex          = '0;
        vectors_loaded = 1'b0;
        seed_draw      = $urandom(9);
        load_vectors();
        if (vectors.size() == 0)
        begin
            $display("No test vectors were read from %s", STIM_FILE);
            error_count++;
        end
        vectors_loaded = 1'b1;

        // Reset over three rising edges, inputs idle
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        inspect_reset();
        rst_n = 1'b1;

        // New vector each falling edge, its result one cycle later
        foreach (vectors[idx])
        begin
            driven = fill_dont_cares(vectors[idx].id_ex);
            id_ex  = driven;
            @(negedge clk);
            score_vector(vectors[idx], driven);
        end
        id_ex = '0;
        @(negedge clk);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog, scaled by vector count
    initial
    begin
        int limit_ns;
        wait (vectors_loaded === 1'b1);
        limit_ns = (vectors.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* test/ex_stim.txt */
# id valid pc_plus4 reg_a reg_b imm use_imm class funct branch jump_index rd rw mr mw
# expected: valid alu_result rw mr mw redirect redirect_pc (all columns hex)
01 1 00400004 00000005 00000003 00000000 0 2 20 0 0000000 03 1 0 0 1 00000008 1 0 0 0 00000000
02 1 00400008 ffffffff 00000002 00000000 0 2 21 0 0000000 04 1 0 0 1 00000001 1 0 0 0 00000000
03 1 0040000c 00000010 00000003 00000000 0 2 22 0 0000000 05 1 0 0 1 0000000d 1 0 0 0 00000000
04 1 00400010 00000003 00000005 00000000 0 2 23 0 0000000 06 1 0 0 1 fffffffe 1 0 0 0 00000000
05 1 00400014 f0f0f0f0 0ff00ff0 00000000 0 2 24 0 0000000 07 1 0 0 1 00f000f0 1 0 0 0 00000000
06 1 00400018 f0f0f0f0 0ff00ff0 00000000 0 2 25 0 0000000 08 1 0 0 1 fff0fff0 1 0 0 0 00000000
07 1 0040001c f0f0f0f0 0ff00ff0 00000000 0 2 26 0 0000000 09 1 0 0 1 ff00ff00 1 0 0 0 00000000
08 1 00400020 f0f0f0f0 0ff00ff0 00000000 0 2 27 0 0000000 0a 1 0 0 1 000f000f 1 0 0 0 00000000
09 1 00400024 00000001 80000000 00000000 0 2 2a 0 0000000 0b 1 0 0 1 00000001 1 0 0 0 00000000
0a 1 00400028 80000000 00000001 00000000 0 2 2a 0 0000000 0c 1 0 0 1 00000000 1 0 0 0 00000000
0b 1 0040002c 12345678 9abcdef0 00000000 0 2 3f 0 0000000 0d 1 0 0 1 ffffffff 1 0 0 0 00000000
0c 1 00400030 00000100 deadbeef fffffffc 1 0 00 0 0000000 0e 1 0 0 1 000000fc 1 0 0 0 00000000
0d 1 00400034 12340000 00000000 00005678 1 3 00 0 0000000 0f 1 0 0 1 12345678 1 0 0 0 00000000
0e 1 00400038 10000000 00000000 00000010 1 0 00 0 0000000 10 1 1 0 1 10000010 1 1 0 0 00000000
0f 1 0040003c 10000000 cafebabe fffffff8 1 0 00 0 0000000 00 0 0 1 1 0ffffff8 0 0 1 0 00000000
10 1 00400044 00000007 00000007 00000004 0 1 00 1 0000000 00 0 0 0 1 00000000 0 0 0 1 00400054
11 1 00400048 00000007 00000008 00000010 0 1 00 1 0000000 00 0 0 0 1 ffffffff 0 0 0 0 00400054
12 1 0040004c 00000009 00000002 fffffffc 0 1 00 2 0000000 00 0 0 0 1 00000007 0 0 0 1 0040003c
13 1 00400050 00000005 00000005 00000020 0 1 00 2 0000000 00 0 0 0 1 00000000 0 0 0 0 0040003c
14 1 00400058 00000000 00000000 00000000 0 0 00 3 0100020 00 0 0 0 1 00000000 0 0 0 1 00400080
15 1 9000005c 00000000 00000000 00000000 0 0 00 3 3ffffff 00 0 0 0 1 00000000 0 0 0 1 9ffffffc
16 1 a0000004 00000003 00000004 00000000 0 0 00 3 0000010 00 0 0 0 1 00000007 0 0 0 1 a0000040
17 0 00400064 00000000 00000000 00000000 0 0 00 3 0000123 01 1 1 1 0 00000000 0 0 0 0 a0000040
18 0 00400068 00000001 00000001 00000008 0 1 00 1 0000000 00 0 0 0 0 00000000 0 0 0 0 a0000040
19 1 0040006c 00000001 00000001 00000000 0 2 20 0 0000000 11 1 0 0 1 00000002 1 0 0 0 a0000040
1a 1 00400070 55555555 55555555 00000000 0 2 22 0 0000000 12 1 0 0 1 00000000 1 0 0 0 a0000040
1b 1 00400074 00000011 00000011 00000001 0 1 00 1 0000000 00 0 0 0 1 00000000 0 0 0 1 00400078
1c 1 00400078 00000000 00000000 00000000 0 2 26 0 0000000 13 1 0 0 1 00000000 1 0 0 0 00400078

/* compile.f */
hw/ex_pkg.sv
hw/alu_control.sv
hw/alu.sv
hw/branch_addr_unit.sv
hw/ex_mem_reg.sv
hw/ex_stage.sv
test/ex_stage_props.sv
test/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  # Design, package first
  - hw/ex_pkg.sv
  - hw/alu_control.sv
  - hw/alu.sv
  - hw/branch_addr_unit.sv
  - hw/ex_mem_reg.sv
  - hw/ex_stage.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/ex_stage_props.sv
      - test/tb_ex_stage.sv
